// ==== all.f ====
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_ram.sv
rtl/dcache_lookup.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
tests/dcache_sva.sv
tests/dcache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= dcache_tb
FILELIST  ?= all.f
BUILD     ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   list the targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tests/dcache_tb.sv ====
// dcache_tb: clock, reset, LFSR stimulus, memory model, reference model, checker, watchdog
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_tb;

  localparam int NUM_RANDOM   = 300;
  localparam int NUM_REQ      = NUM_RANDOM + 24;
  localparam int WORST_CYCLES = 80;  // write-back plus refill with slow ready
  localparam int LINE_BITS    = `DCACHE_WORDS * `DCACHE_WORD_BITS;

  logic                 clk = 1'b0;
  logic                 rst_n = 1'b0;
  logic                 cpu_valid = 1'b0;
  logic                 cpu_op = 1'b0;
  logic [31:0]          cpu_addr = '0;
  logic [3:0]           cpu_wstrb = '0;
  logic [31:0]          cpu_wdata = '0;
  logic                 cpu_addr_ok;
  logic                 cpu_data_ok;
  logic [31:0]          cpu_rdata;
  logic                 mem_rd_req;
  logic [31:0]          mem_rd_addr;
  logic                 mem_rd_rdy = 1'b0;
  logic                 mem_ret_valid = 1'b0;
  logic [LINE_BITS-1:0] mem_ret_data = '0;
  logic                 mem_wr_req;
  logic [31:0]          mem_wr_addr;
  logic [LINE_BITS-1:0] mem_wr_data;
  logic                 mem_wr_rdy = 1'b0;
  logic                 mem_wr_valid = 1'b0;

  logic [31:0]          lfsr = 32'ha7fd_7a14;
  logic [31:0]          shadow [logic [31:0]];     // latest stored words
  logic [LINE_BITS-1:0] mem_lines [logic [31:0]];  // written-back lines
  int                   errors = 0;
  int                   checks = 0;
  int                   rd_count = 0;
  int                   wr_count = 0;
  logic [31:0]          last_rd_addr = '0;
  logic [31:0]          last_wr_addr = '0;
  logic                 rd_pending = 1'b0;
  logic                 wr_pending = 1'b0;
  logic [31:0]          rd_line = '0;
  int                   rd_delay = 0;
  int                   wr_delay = 0;
  logic                 exp_load = 1'b0;
  logic [31:0]          exp_data = '0;

  dcache_top i_dcache_top (.*);

  always #10 clk = ~clk;

  function automatic logic next_bit();
    logic lsb;
    lsb  = lfsr[0];
    lfsr = lfsr >> 1;
    if (lsb) begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
    return lsb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], next_bit()};
    end
    return v;
  endfunction

  // memory contents before any write depend on every address bit
  function automatic logic [31:0] init_word(input logic [31:0] a);
    return (a * 32'h9e37_79b9) ^ {a[7:0], a[31:8]};
  endfunction

  function automatic logic [31:0] ref_load(input logic [31:0] a);
    if (shadow.exists(a)) begin
      return shadow[a];
    end
    return init_word(a);
  endfunction

  function automatic void ref_store(input logic [31:0] a, input logic [3:0] strb,
                                    input logic [31:0] d);
    logic [31:0] w;
    w = ref_load(a);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        w[b*8 +: 8] = d[b*8 +: 8];
      end
    end
    shadow[a] = w;
  endfunction

  function automatic logic [LINE_BITS-1:0] read_line(input logic [31:0] la);
    logic [LINE_BITS-1:0] l;
    if (mem_lines.exists(la)) begin
      return mem_lines[la];
    end
    for (int w = 0; w < `DCACHE_WORDS; w++) begin
      l[w*32 +: 32] = init_word(la + 32'(w * 4));
    end
    return l;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("error at %0t: %s", $time, what);
      errors++;
    end
  endtask

  // memory model answers on the falling edge
  always @(negedge clk) begin
    mem_ret_valid = 1'b0;
    mem_wr_valid  = 1'b0;
    mem_rd_rdy    = 1'b0;
    mem_wr_rdy    = 1'b0;
    if (rd_pending) begin
      if (rd_delay == 0) begin
        mem_ret_valid = 1'b1;
        mem_ret_data  = read_line(rd_line);
        rd_pending    = 1'b0;
      end else begin
        rd_delay--;
      end
    end
    if (wr_pending) begin
      if (wr_delay == 0) begin
        mem_wr_valid = 1'b1;
        wr_pending   = 1'b0;
      end else begin
        wr_delay--;
      end
    end
    if (rst_n && mem_rd_req && !rd_pending && rand_bits(1) != 0) begin
      mem_rd_rdy   = 1'b1;
      rd_pending   = 1'b1;
      rd_line      = mem_rd_addr;
      rd_delay     = int'(rand_bits(2));
      last_rd_addr = mem_rd_addr;
      rd_count++;
    end
    if (rst_n && mem_wr_req && !wr_pending && rand_bits(1) != 0) begin
      mem_wr_rdy   = 1'b1;
      wr_pending   = 1'b1;
      wr_delay     = int'(rand_bits(2));
      last_wr_addr = mem_wr_addr;
      wr_count++;
      for (int w = 0; w < `DCACHE_WORDS; w++) begin
        check_value("mem_wr_data", ref_load(mem_wr_addr + 32'(w * 4)), mem_wr_data[w*32 +: 32]);
      end
      mem_lines[mem_wr_addr] = mem_wr_data;
    end
  end

  // compares every load result against the reference
  always @(negedge clk) begin
    if (cpu_data_ok && exp_load) begin
      check_value("cpu_rdata", exp_data, cpu_rdata);
    end
  end

  // one request from just after a falling edge
  // lat counts falling edges up to cpu_data_ok
  task automatic access(input logic op, input logic [31:0] addr, input logic [3:0] strb,
                        input logic [31:0] data, output int lat);
    exp_load  = !op;
    exp_data  = ref_load(addr);
    cpu_valid = 1'b1;
    cpu_op    = op;
    cpu_addr  = addr;
    cpu_wstrb = strb;
    cpu_wdata = data;
    while (!cpu_addr_ok) @(negedge clk);
    if (op) begin
      ref_store(addr, strb, data);
    end
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
      cpu_valid = 1'b0;
    end while (!cpu_data_ok);
    @(negedge clk);
  endtask

  task automatic report(input int num, input string name, input int err0);
    $display("test %0d %s: %0d errors", num, name, errors - err0);
  endtask

  initial begin
    int          err0;
    int          lat;
    int          rd0;
    int          wr0;
    logic [31:0] a;

    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    err0 = errors;
    check_value("cpu_addr_ok", 32'd1, 32'(cpu_addr_ok));
    check_value("cpu_data_ok", 32'd0, 32'(cpu_data_ok));
    check_value("mem_rd_req", 32'd0, 32'(mem_rd_req));
    check_value("mem_wr_req", 32'd0, 32'(mem_wr_req));
    report(1, "reset state", err0);

    err0 = errors;
    rd0  = rd_count;
    access(1'b0, 32'h0001_2340, 4'h0, 32'h0, lat);
    check_value("rd_count", 32'(rd0 + 1), 32'(rd_count));
    check_value("mem_rd_addr", 32'h0001_2340, last_rd_addr);
    report(2, "cold load", err0);

    err0 = errors;
    rd0  = rd_count;
    wr0  = wr_count;
    access(1'b0, 32'h0001_2344, 4'h0, 32'h0, lat);
    check_value("hit latency", 32'd1, 32'(lat));
    check_true(rd_count == rd0 && wr_count == wr0, "memory request on a load hit");
    report(3, "load hit", err0);

    err0 = errors;
    for (int i = 0; i < 8; i++) begin
      a = 32'h0001_2340 + (rand_bits(2) << 2);
      access(1'b1, a, rand_bits(4), rand_bits(32), lat);
      access(1'b0, a, 4'h0, 32'h0, lat);
    end
    report(4, "store merge", err0);

    err0 = errors;
    access(1'b1, 32'h000a_0770, 4'hf, rand_bits(32), lat);
    access(1'b0, 32'h000b_0770, 4'h0, 32'h0, lat);
    wr0 = wr_count;
    access(1'b0, 32'h000c_0770, 4'h0, 32'h0, lat);
    check_value("wr_count", 32'(wr0 + 1), 32'(wr_count));
    check_value("mem_wr_addr", 32'h000a_0770, last_wr_addr);
    access(1'b0, 32'h000a_0770, 4'h0, 32'h0, lat);
    report(5, "dirty eviction", err0);

    err0 = errors;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      // four tags over four sets keep both hits and conflicts frequent
      a = 32'h0008_0000 | (rand_bits(2) << 12) | (rand_bits(2) << 4) | (rand_bits(2) << 2);
      if (rand_bits(1) != 0) begin
        access(1'b1, a, rand_bits(4), rand_bits(32), lat);
      end else begin
        access(1'b0, a, 4'h0, 32'h0, lat);
      end
    end
    report(6, "random mix", err0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #((5 + NUM_REQ * WORST_CYCLES) * 20);
    $display("timeout, a request never completed");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== tests/dcache_sva.sv ====
// dcache_sva: concurrent checks on the memory request levels and the store cycle
`timescale 1ns/1ps

module dcache_sva (
  input logic clk,
  input logic rst_n,
  input logic cpu_addr_ok,
  input logic cpu_data_ok,
  input logic req_op,
  input logic mem_rd_req,
  input logic mem_rd_rdy,
  input logic mem_wr_req,
  input logic mem_wr_rdy
);

  rd_wr_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(mem_rd_req && mem_wr_req))
    else $error("refill and write-back requests high together");

  rd_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_rd_req && !mem_rd_rdy) |=> mem_rd_req)
    else $error("mem_rd_req dropped before mem_rd_rdy");

  wr_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_wr_req && !mem_wr_rdy) |=> mem_wr_req)
    else $error("mem_wr_req dropped before mem_wr_rdy");

  // the cycle after a store hit is the line write
  store_cycle_closed: assert property (@(posedge clk) disable iff (!rst_n)
    (cpu_data_ok && req_op) |=> (!cpu_addr_ok && !cpu_data_ok))
    else $error("CPU strobes active during the store write cycle");

endmodule

bind dcache_top dcache_sva i_dcache_sva (
  .clk         (clk),
  .rst_n       (rst_n),
  .cpu_addr_ok (cpu_addr_ok),
  .cpu_data_ok (cpu_data_ok),
  .req_op      (req_op),
  .mem_rd_req  (mem_rd_req),
  .mem_rd_rdy  (mem_rd_rdy),
  .mem_wr_req  (mem_wr_req),
  .mem_wr_rdy  (mem_wr_rdy)
);

// ==== rtl/dcache_top.sv ====
// dcache_top: request stage, controller, two tag arrays and two line arrays
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_top
  import dcache_pkg::*;
(
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        cpu_valid,
  input  logic                                        cpu_op,
  input  logic [31:0]                                 cpu_addr,
  input  logic [`DCACHE_WORD_BITS/8-1:0]              cpu_wstrb,
  input  logic [`DCACHE_WORD_BITS-1:0]                cpu_wdata,
  output logic                                        cpu_addr_ok,
  output logic                                        cpu_data_ok,
  output logic [`DCACHE_WORD_BITS-1:0]                cpu_rdata,
  output logic                                        mem_rd_req,
  output logic [31:0]                                 mem_rd_addr,
  input  logic                                        mem_rd_rdy,
  input  logic                                        mem_ret_valid,
  input  logic [`DCACHE_WORDS*`DCACHE_WORD_BITS-1:0]  mem_ret_data,
  output logic                                        mem_wr_req,
  output logic [31:0]                                 mem_wr_addr,
  output logic [`DCACHE_WORDS*`DCACHE_WORD_BITS-1:0]  mem_wr_data,
  input  logic                                        mem_wr_rdy,
  input  logic                                        mem_wr_valid
);

  logic                           replay;
  logic                           refill_way0_we;
  logic                           refill_way1_we;
  logic [`DCACHE_INDEX_BITS-1:0]  array_index;
  logic                           array_en;
  logic                           req_op;
  logic [`DCACHE_INDEX_BITS-1:0]  req_index;
  logic [`DCACHE_TAG_BITS-1:0]    req_tag;
  logic                           hit0;
  logic                           hit1;
  logic [`DCACHE_WORD_BITS-1:0]   hit_word;
  cache_line_t                    store_line;
  logic                           store_way;
  tag_entry_t                     tag0_q;
  tag_entry_t                     tag1_q;
  cache_line_t                    line0_q;
  cache_line_t                    line1_q;
  logic                           tag_we0;
  logic                           tag_we1;
  tag_entry_t                     tag_din;
  logic                           line_we0;
  logic                           line_we1;
  cache_line_t                    line_din;

  dcache_lookup i_lookup (
    .clk            (clk),
    .rst_n          (rst_n),
    .cpu_valid      (cpu_valid),
    .cpu_op         (cpu_op),
    .cpu_addr       (cpu_addr),
    .cpu_wstrb      (cpu_wstrb),
    .cpu_wdata      (cpu_wdata),
    .accept         (cpu_addr_ok),
    .replay         (replay),
    .refill_way0_we (refill_way0_we),
    .refill_way1_we (refill_way1_we),
    .tag0_q         (tag0_q),
    .tag1_q         (tag1_q),
    .line0_q        (line0_q),
    .line1_q        (line1_q),
    .array_index    (array_index),
    .array_en       (array_en),
    .req_op         (req_op),
    .req_index      (req_index),
    .req_tag        (req_tag),
    .hit0           (hit0),
    .hit1           (hit1),
    .hit_word       (hit_word),
    .store_line     (store_line),
    .store_way      (store_way)
  );

  dcache_ctrl i_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .cpu_valid      (cpu_valid),
    .req_op         (req_op),
    .req_index      (req_index),
    .req_tag        (req_tag),
    .hit0           (hit0),
    .hit1           (hit1),
    .hit_word       (hit_word),
    .store_line     (store_line),
    .store_way      (store_way),
    .tag0_q         (tag0_q),
    .tag1_q         (tag1_q),
    .line0_q        (line0_q),
    .line1_q        (line1_q),
    .mem_rd_rdy     (mem_rd_rdy),
    .mem_ret_valid  (mem_ret_valid),
    .mem_ret_data   (mem_ret_data),
    .mem_wr_rdy     (mem_wr_rdy),
    .mem_wr_valid   (mem_wr_valid),
    .accept         (cpu_addr_ok),
    .replay         (replay),
    .cpu_data_ok    (cpu_data_ok),
    .cpu_rdata      (cpu_rdata),
    .refill_way0_we (refill_way0_we),
    .refill_way1_we (refill_way1_we),
    .tag_we0        (tag_we0),
    .tag_we1        (tag_we1),
    .tag_din        (tag_din),
    .line_we0       (line_we0),
    .line_we1       (line_we1),
    .line_din       (line_din),
    .mem_rd_req     (mem_rd_req),
    .mem_rd_addr    (mem_rd_addr),
    .mem_wr_req     (mem_wr_req),
    .mem_wr_addr    (mem_wr_addr),
    .mem_wr_data    (mem_wr_data)
  );

  // way 0 tags
  dcache_ram #(.PAYLOAD_T(tag_entry_t), .DEPTH(`DCACHE_SETS)) i_tag0 (
    .clk  (clk),
    .en   (array_en),
    .we   (tag_we0),
    .addr (array_index),
    .din  (tag_din),
    .dout (tag0_q)
  );

  dcache_ram #(.PAYLOAD_T(tag_entry_t), .DEPTH(`DCACHE_SETS)) i_tag1 (
    .clk  (clk),
    .en   (array_en),
    .we   (tag_we1),
    .addr (array_index),
    .din  (tag_din),
    .dout (tag1_q)
  );

  // whole-line data arrays
  dcache_ram #(.PAYLOAD_T(cache_line_t), .DEPTH(`DCACHE_SETS)) i_line0 (
    .clk  (clk),
    .en   (array_en),
    .we   (line_we0),
    .addr (array_index),
    .din  (line_din),
    .dout (line0_q)
  );

  dcache_ram #(.PAYLOAD_T(cache_line_t), .DEPTH(`DCACHE_SETS)) i_line1 (
    .clk  (clk),
    .en   (array_en),
    .we   (line_we1),
    .addr (array_index),
    .din  (line_din),
    .dout (line1_q)
  );

endmodule

// ==== rtl/dcache_ctrl.sv ====
// dcache_ctrl: miss FSM, dirty bits, last-hit bit, array writes, CPU strobes, memory requests
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_ctrl
  import dcache_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           cpu_valid,
  input  logic                           req_op,
  input  logic [`DCACHE_INDEX_BITS-1:0]  req_index,
  input  logic [`DCACHE_TAG_BITS-1:0]    req_tag,
  input  logic                           hit0,
  input  logic                           hit1,
  input  logic [`DCACHE_WORD_BITS-1:0]   hit_word,
  input  cache_line_t                    store_line,
  input  logic                           store_way,
  input  tag_entry_t                     tag0_q,
  input  tag_entry_t                     tag1_q,
  input  cache_line_t                    line0_q,
  input  cache_line_t                    line1_q,
  input  logic                           mem_rd_rdy,
  input  logic                           mem_ret_valid,
  input  cache_line_t                    mem_ret_data,
  input  logic                           mem_wr_rdy,
  input  logic                           mem_wr_valid,
  output logic                           accept,
  output logic                           replay,
  output logic                           cpu_data_ok,
  output logic [`DCACHE_WORD_BITS-1:0]   cpu_rdata,
  output logic                           refill_way0_we,
  output logic                           refill_way1_we,
  output logic                           tag_we0,
  output logic                           tag_we1,
  output tag_entry_t                     tag_din,
  output logic                           line_we0,
  output logic                           line_we1,
  output cache_line_t                    line_din,
  output logic                           mem_rd_req,
  output logic [31:0]                    mem_rd_addr,
  output logic                           mem_wr_req,
  output logic [31:0]                    mem_wr_addr,
  output cache_line_t                    mem_wr_data
);

  cache_state_t                 state;
  cache_state_t                 state_nx;
  logic [`DCACHE_SETS-1:0]      dirty0;
  logic [`DCACHE_SETS-1:0]      dirty1;
  logic                         last_hit;   // 1 when way 1 hit last
  logic                         hit;
  logic                         victim;
  logic                         victim_dirty;
  logic [`DCACHE_TAG_BITS-1:0]  victim_tag;
  logic                         refill_fill;
  logic                         store_wr;

  assign hit          = hit0 || hit1;
  assign victim       = ~last_hit;
  assign victim_dirty = victim ? dirty1[req_index] : dirty0[req_index];
  assign victim_tag   = victim ? tag1_q.tag : tag0_q.tag;

  always_comb begin
    state_nx = state;
    case (state)
      st_idle: begin
        if (replay || cpu_valid) begin
          state_nx = st_lookup;
        end
      end
      st_lookup: begin
        if (!hit) begin
          state_nx = victim_dirty ? st_miss_dirty : st_miss_clean;
        end else if (req_op) begin
          state_nx = st_store;
        end else if (!cpu_valid) begin
          state_nx = st_idle;
        end
      end
      st_store:      state_nx = st_idle;
      st_miss_dirty: state_nx = mem_wr_rdy ? st_writeback : st_miss_dirty;
      st_writeback:  state_nx = mem_wr_valid ? st_miss_clean : st_writeback;
      st_miss_clean: state_nx = mem_rd_rdy ? st_refill : st_miss_clean;
      st_refill:     state_nx = mem_ret_valid ? st_idle : st_refill;
      default:       state_nx = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= st_idle;
      replay <= 1'b0;
    end else begin
      state  <= state_nx;
      replay <= refill_fill;  // one idle cycle that reissues the buffered request
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_hit <= 1'b0;
    end else if (state == st_lookup && hit) begin
      last_hit <= hit1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dirty0 <= '0;
      dirty1 <= '0;
    end else if (state == st_lookup && hit && req_op) begin
      if (hit1) begin
        dirty1[req_index] <= 1'b1;
      end else begin
        dirty0[req_index] <= 1'b1;
      end
    end else if (state == st_writeback) begin
      if (victim) begin
        dirty1[req_index] <= 1'b0;
      end else begin
        dirty0[req_index] <= 1'b0;
      end
    end
  end

  // array writes
  assign refill_fill    = (state == st_refill) && mem_ret_valid;
  assign store_wr       = (state == st_store);
  assign refill_way0_we = refill_fill && !victim;
  assign refill_way1_we = refill_fill && victim;
  assign tag_we0        = refill_way0_we;
  assign tag_we1        = refill_way1_we;
  assign tag_din        = '{tag: req_tag};
  assign line_we0       = refill_way0_we || (store_wr && !store_way);
  assign line_we1       = refill_way1_we || (store_wr && store_way);
  assign line_din       = store_wr ? store_line : mem_ret_data;

  // load hits keep the pipe open, a store hit closes it for the write
  assign accept      = (state == st_idle && !replay) ||
                       (state == st_lookup && hit && !req_op);
  assign cpu_data_ok = (state == st_lookup) && hit;
  assign cpu_rdata   = hit_word;

  assign mem_rd_req  = (state == st_miss_clean);
  assign mem_rd_addr = {req_tag, req_index, {`DCACHE_OFFSET_BITS{1'b0}}};
  assign mem_wr_req  = (state == st_miss_dirty);
  assign mem_wr_addr = {victim_tag, req_index, {`DCACHE_OFFSET_BITS{1'b0}}};
  assign mem_wr_data = victim ? line1_q : line0_q;

endmodule

// ==== rtl/dcache_lookup.sv ====
// dcache_lookup: request register, replay select, array index, valid bits, hit check, store merge
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_lookup
  import dcache_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           cpu_valid,
  input  logic                           cpu_op,
  input  logic [31:0]                    cpu_addr,
  input  logic [`DCACHE_WORD_BITS/8-1:0] cpu_wstrb,
  input  logic [`DCACHE_WORD_BITS-1:0]   cpu_wdata,
  input  logic                           accept,
  input  logic                           replay,
  input  logic                           refill_way0_we,
  input  logic                           refill_way1_we,
  input  tag_entry_t                     tag0_q,
  input  tag_entry_t                     tag1_q,
  input  cache_line_t                    line0_q,
  input  cache_line_t                    line1_q,
  output logic [`DCACHE_INDEX_BITS-1:0]  array_index,
  output logic                           array_en,
  output logic                           req_op,
  output logic [`DCACHE_INDEX_BITS-1:0]  req_index,
  output logic [`DCACHE_TAG_BITS-1:0]    req_tag,
  output logic                           hit0,
  output logic                           hit1,
  output logic [`DCACHE_WORD_BITS-1:0]   hit_word,
  output cache_line_t                    store_line,
  output logic                           store_way
);

  localparam int IDX_LSB   = `DCACHE_OFFSET_BITS;
  localparam int TAG_LSB   = `DCACHE_OFFSET_BITS + `DCACHE_INDEX_BITS;
  localparam int WSEL_BITS = $clog2(`DCACHE_WORDS);
  localparam int BYTES     = `DCACHE_WORD_BITS / 8;

  cache_req_t                 cpu_req;
  cache_req_t                 req_q;
  cache_req_t                 live_req;
  logic [`DCACHE_SETS-1:0]    valid0;
  logic [`DCACHE_SETS-1:0]    valid1;
  logic [WSEL_BITS-1:0]       word_sel;
  cache_line_t                hit_line;
  cache_line_t                merged_line;

  assign cpu_req = '{
    valid:  cpu_valid,
    op:     cpu_op,
    tag:    cpu_addr[TAG_LSB +: `DCACHE_TAG_BITS],
    index:  cpu_addr[IDX_LSB +: `DCACHE_INDEX_BITS],
    offset: cpu_addr[`DCACHE_OFFSET_BITS-1:0],
    wstrb:  cpu_wstrb,
    wdata:  cpu_wdata
  };

  // while the controller is busy the arrays keep pointing at the buffered set
  assign live_req    = (replay || !accept) ? req_q : cpu_req;
  assign array_index = live_req.index;
  assign array_en    = live_req.valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_q.valid <= 1'b0;
    end else if (accept) begin
      req_q <= cpu_req;
    end
  end

  // one valid bit per set and way
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid0 <= '0;
      valid1 <= '0;
    end else begin
      if (refill_way0_we) begin
        valid0[req_q.index] <= 1'b1;
      end
      if (refill_way1_we) begin
        valid1[req_q.index] <= 1'b1;
      end
    end
  end

  assign hit0 = valid0[req_q.index] && (tag0_q.tag == req_q.tag);
  assign hit1 = valid1[req_q.index] && (tag1_q.tag == req_q.tag);

  assign word_sel = req_q.offset[`DCACHE_OFFSET_BITS-1 -: WSEL_BITS];
  assign hit_line = hit1 ? line1_q : line0_q;
  assign hit_word = hit_line[word_sel];

  always_comb begin
    merged_line = hit_line;
    for (int b = 0; b < BYTES; b++) begin
      if (req_q.wstrb[b]) begin
        merged_line[word_sel][b*8 +: 8] = req_q.wdata[b*8 +: 8];
      end
    end
  end

  // merged line waits one cycle for the store write
  always_ff @(posedge clk) begin
    if (req_q.op && (hit0 || hit1)) begin
      store_line <= merged_line;
      store_way  <= hit1;
    end
  end

  assign req_op    = req_q.op;
  assign req_index = req_q.index;
  assign req_tag   = req_q.tag;

endmodule

// ==== rtl/dcache_ram.sv ====
// dcache_ram: single-port synchronous array with read-first output, payload set by type
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_ram #(
  parameter type PAYLOAD_T = logic [`DCACHE_WORD_BITS-1:0],
  parameter int  DEPTH     = `DCACHE_SETS
) (
  input  logic                     clk,
  input  logic                     en,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  PAYLOAD_T                 din,
  output PAYLOAD_T                 dout
);

  PAYLOAD_T mem [DEPTH];

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= din;
      end
      dout <= mem[addr];  // old contents on a write cycle
    end
  end

endmodule

// ==== rtl/dcache_pkg.sv ====
// dcache_pkg: controller state enum, tag entry, cache line and buffered request types
`include "dcache_defines.svh"

package dcache_pkg;

  typedef enum logic [3:0] {
    st_idle,
    st_lookup,
    st_store,       // hit line written back into its way
    st_miss_clean,
    st_miss_dirty,
    st_writeback,   // waiting for write completion
    st_refill
  } cache_state_t;

  typedef struct packed {
    logic [`DCACHE_TAG_BITS-1:0] tag;
  } tag_entry_t;

  // word 0 sits in the low bits
  typedef logic [`DCACHE_WORDS-1:0][`DCACHE_WORD_BITS-1:0] cache_line_t;

  typedef struct packed {
    logic                            valid;
    logic                            op;      // 0 load, 1 store
    logic [`DCACHE_TAG_BITS-1:0]     tag;
    logic [`DCACHE_INDEX_BITS-1:0]   index;
    logic [`DCACHE_OFFSET_BITS-1:0]  offset;
    logic [`DCACHE_WORD_BITS/8-1:0]  wstrb;
    logic [`DCACHE_WORD_BITS-1:0]    wdata;
  } cache_req_t;

endpackage

// ==== rtl/dcache_defines.svh ====
// cache geometry macros: sets, index, offset, words per line, tag and word widths
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// two ways of 256 sets, 16-byte lines
`define DCACHE_SETS        256
`define DCACHE_INDEX_BITS  8
`define DCACHE_OFFSET_BITS 4
`define DCACHE_WORDS       4

// physical address bits 31:12
`define DCACHE_TAG_BITS    20
`define DCACHE_WORD_BITS   32

`endif
